// ==== Bender.yml ====
package:
  name: opl_rhythm

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/opl_pkg.sv
      - hdl/phase_regs_axil.sv
      - hdl/slot_sequencer.sv
      - hdl/phase_accumulator.sv
      - hdl/rhythm_phase.sv
      - hdl/opl_rhythm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/opl_rhythm_properties.sv
      - tests/opl_rhythm_tb.sv

// ==== hdl/opl_pkg.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

package opl_pkg;

    //////////////////////////////////////////////////
    // Plain vectors
    //////////////////////////////////////////////////
    typedef logic [`OPL_SLOT_WIDTH-1:0] slot_num_t;         // Slot index.
    typedef logic [`OPL_PHASE_ACC_WIDTH-1:0] phase_acc_t;   // Full accumulator.
    typedef logic [`OPL_PHASE_WIDTH-1:0] phase_t;           // Truncated phase.
    typedef logic [`OPL_INC_WIDTH-1:0] phase_inc_t;         // Added once per sample.

    //////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        OP_NORMAL,          // Melodic operator.
        OP_HI_HAT,
        OP_SNARE_DRUM,
        OP_TOM_TOM,         // Rhythm voice, phase untouched.
        OP_TOP_CYMBAL
    } op_type_t;

    typedef enum logic {
        SEQ_ISSUE,          // Slots going out.
        SEQ_IDLE            // Rest of the sample period.
    } seq_state_t;

    //////////////////////////////////////////////////
    // Pipeline records
    //////////////////////////////////////////////////
    typedef struct packed {
        logic       valid;          // Slot present in this stage.
        logic       sample_start;   // Slot 0 of the period.
        slot_num_t  slot_num;
        op_type_t   op_type;
    } slot_t;

    typedef struct packed {
        logic       valid;
        slot_num_t  slot_num;
        phase_t     phase;          // After rhythm rewrite.
    } phase_out_t;

    // Increment table, index is the slot number.
    typedef phase_inc_t [`OPL_NUM_SLOTS-1:0] inc_array_t;

endpackage

`default_nettype wire

// ==== hdl/opl_rhythm_top.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

module opl_rhythm_top (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire  [`OPL_AXIL_ADDR_WIDTH-1:0]   awaddr,
    input  wire                               awvalid,
    output logic                              awready,
    input  wire  [`OPL_AXIL_DATA_WIDTH-1:0]   wdata,
    input  wire  [`OPL_AXIL_DATA_WIDTH/8-1:0] wstrb,
    input  wire                               wvalid,
    output logic                              wready,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  wire                               bready,
    input  wire  [`OPL_AXIL_ADDR_WIDTH-1:0]   araddr,
    input  wire                               arvalid,
    output logic                              arready,
    output logic [`OPL_AXIL_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  wire                               rready,
    output opl_pkg::phase_out_t               phase_out  // Valid 3 cycles after issue.
);
    import opl_pkg::*;

    inc_array_t inc;        // Register block to accumulator.
    logic       rhythm_en;
    slot_t      slot_p0;    // Issued slot.
    slot_t      slot_p2;
    phase_t     phase_p2;   // Truncated phase.

    phase_regs_axil i_regs (
        .clk, .arst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .inc, .rhythm_en
    );

    slot_sequencer i_seq (
        .clk, .arst_n,
        .rhythm_en,
        .slot_p0
    );

    phase_accumulator i_acc (
        .clk, .arst_n,
        .inc,
        .slot_p0,
        .slot_p2,
        .phase_p2
    );

    rhythm_phase i_rhythm (
        .clk, .arst_n,
        .slot_p2,
        .phase_p2,
        .phase_out
    );

endmodule

`default_nettype wire

// ==== hdl/phase_accumulator.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

module phase_accumulator (
    input  wire                 clk,
    input  wire                 arst_n,
    input  var  opl_pkg::inc_array_t inc,
    input  var  opl_pkg::slot_t slot_p0,
    output opl_pkg::slot_t      slot_p2,
    output opl_pkg::phase_t     phase_p2
);
    import opl_pkg::*;

    localparam int ACC_W   = `OPL_PHASE_ACC_WIDTH;
    localparam int PHASE_W = `OPL_PHASE_WIDTH;

    phase_acc_t acc_mem [`OPL_NUM_SLOTS];  // One phase per slot.
    slot_t      slot_p1;
    phase_acc_t acc_p1;                    // Stored value of the slot in p1.
    phase_acc_t sum_p1;                    // Advanced value, wraps.

    //////////////////////////////////////////////////
    // Stage p1, read and add
    //////////////////////////////////////////////////
    assign acc_p1 = acc_mem[slot_p1.slot_num];
    assign sum_p1 = acc_p1 + ACC_W'(inc[slot_p1.slot_num]);  // Mod 2**20.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_p1 <= '0;
            for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
                acc_mem[i] <= '0;                  // All phases start at zero.
            end
        end else begin
            slot_p1 <= slot_p0;
            if (slot_p1.valid) begin
                acc_mem[slot_p1.slot_num] <= sum_p1;  // Write back.
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage p2, truncated phase
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_p2  <= '0;
            phase_p2 <= '0;
        end else begin
            slot_p2 <= slot_p1;                    // Carry slot info along.
            if (slot_p1.valid) begin
                phase_p2 <= sum_p1[ACC_W-1 -: PHASE_W];  // Top bits of new value.
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/phase_regs_axil.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

module phase_regs_axil (
    input  wire                               clk,
    input  wire                               arst_n,
    // Write address.
    input  wire  [`OPL_AXIL_ADDR_WIDTH-1:0]   awaddr,
    input  wire                               awvalid,
    output logic                              awready,
    // Write data.
    input  wire  [`OPL_AXIL_DATA_WIDTH-1:0]   wdata,
    input  wire  [`OPL_AXIL_DATA_WIDTH/8-1:0] wstrb,
    input  wire                               wvalid,
    output logic                              wready,
    // Write response.
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  wire                               bready,
    // Read address.
    input  wire  [`OPL_AXIL_ADDR_WIDTH-1:0]   araddr,
    input  wire                               arvalid,
    output logic                              arready,
    // Read data.
    output logic [`OPL_AXIL_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  wire                               rready,
    // Register contents.
    output opl_pkg::inc_array_t               inc,
    output logic                              rhythm_en
);
    import opl_pkg::*;

    localparam int ADDR_W    = `OPL_AXIL_ADDR_WIDTH;
    localparam int DATA_W    = `OPL_AXIL_DATA_WIDTH;
    localparam int INC_BYTES = `OPL_INC_WIDTH / 8;     // Bytes covered by wstrb.

    logic              wr_start;  // Both halves present, nothing pending.
    logic              wr_fire;   // Write handshake this cycle.
    logic              rd_start;
    logic              rd_fire;   // Read address handshake this cycle.
    logic [DATA_W-1:0] rd_word;   // Decoded read value.

    // Word index compare, low two bits select a byte.
    function automatic logic inc_hit(input logic [ADDR_W-1:0] addr, input int idx);
        return int'(addr[ADDR_W-1:2]) == (`OPL_REG_INC_BASE >> 2) + idx;
    endfunction

    function automatic logic rhythm_hit(input logic [ADDR_W-1:0] addr);
        return int'(addr[ADDR_W-1:2]) == (`OPL_REG_RHYTHM >> 2);
    endfunction

    assign wr_start = awvalid && wvalid && !awready && !bvalid;
    assign wr_fire  = awvalid && awready && wvalid && wready;
    assign rd_start = arvalid && !arready && !rvalid;
    assign rd_fire  = arvalid && arready;
    assign bresp    = `OPL_AXIL_RESP_OKAY;  // Every access answers OKAY.
    assign rresp    = `OPL_AXIL_RESP_OKAY;

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            inc       <= '0;
            rhythm_en <= 1'b0;
        end else begin
            awready <= wr_start;            // One-cycle ready pulse.
            wready  <= wr_start;
            if (wr_fire) begin
                bvalid <= 1'b1;             // Held until bready.
                for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
                    if (inc_hit(awaddr, i)) begin
                        for (int b = 0; b < INC_BYTES; b++) begin
                            if (wstrb[b]) begin
                                inc[i][8*b +: 8] <= wdata[8*b +: 8];
                            end
                        end
                    end
                end
                if (rhythm_hit(awaddr) && wstrb[0]) begin
                    rhythm_en <= wdata[0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;             // Response taken.
            end
        end
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////
    always_comb begin
        rd_word = '0;                       // Unmapped reads as zero.
        for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
            if (inc_hit(araddr, i)) begin
                rd_word = DATA_W'(inc[i]);
            end
        end
        if (rhythm_hit(araddr)) begin
            rd_word = DATA_W'(rhythm_en);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= rd_start;
            if (rd_fire) begin
                rvalid <= 1'b1;             // Data one cycle after address.
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;               // Stable while rvalid is held.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rhythm_phase.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

module rhythm_phase (
    input  wire                 clk,
    input  wire                 arst_n,
    input  var  opl_pkg::slot_t slot_p2,
    input  var  opl_pkg::phase_t phase_p2,
    output opl_pkg::phase_out_t phase_out
);
    import opl_pkg::*;

    localparam int NOISE_W = `OPL_NOISE_WIDTH;

    phase_t             hh_friend;        // Last hi-hat phase seen.
    phase_t             tc_friend;        // Last top cymbal phase seen.
    phase_t             hh_phase;         // Current or stored hi-hat phase.
    phase_t             tc_phase;
    logic               rm_bit;           // Ring-modulation bit.
    logic [NOISE_W-1:0] noise;
    logic               noise_fb;         // LFSR feedback.
    phase_t             rhythm_phase_p2;  // Rewritten phase, before register.

    //////////////////////////////////////////////////
    // Friend phases
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hh_friend <= '0;
            tc_friend <= '0;
        end else if (slot_p2.valid) begin
            if (slot_p2.slot_num == slot_num_t'(`OPL_SLOT_HH)) begin
                hh_friend <= phase_p2;    // Hi-hat passing by.
            end
            if (slot_p2.slot_num == slot_num_t'(`OPL_SLOT_TC)) begin
                tc_friend <= phase_p2;    // Top cymbal passing by.
            end
        end
    end

    // The slot's own phase wins over the stored copy.
    always_comb begin
        hh_phase = (slot_p2.op_type == OP_HI_HAT) ? phase_p2 : hh_friend;
        tc_phase = (slot_p2.op_type == OP_TOP_CYMBAL) ? phase_p2 : tc_friend;
        rm_bit   = (hh_phase[2] ^ hh_phase[7])
                 | (hh_phase[3] ^ hh_phase[5])
                 | (tc_phase[3] ^ tc_phase[5]);
    end

    //////////////////////////////////////////////////
    // Noise LFSR
    //////////////////////////////////////////////////
    assign noise_fb = noise[0] ^ noise[14];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            noise <= NOISE_W'(1);         // Nonzero seed.
        end else if (slot_p2.valid && slot_p2.sample_start) begin
            noise <= {noise_fb, noise[NOISE_W-1:1]};  // Once per sample.
        end
    end

    //////////////////////////////////////////////////
    // Phase rewrite
    //////////////////////////////////////////////////
    always_comb begin
        case (slot_p2.op_type)
            OP_HI_HAT: begin
                rhythm_phase_p2 = {rm_bit, (rm_bit ^ noise[0]) ? 9'h0d0 : 9'h034};
            end
            OP_SNARE_DRUM: begin
                rhythm_phase_p2 = {hh_phase[8], hh_phase[8] ^ noise[0], 8'h00};
            end
            OP_TOP_CYMBAL: begin
                rhythm_phase_p2 = {rm_bit, 9'h080};
            end
            default: rhythm_phase_p2 = phase_p2;   // Normal and tom pass.
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_out <= '0;
        end else begin
            phase_out.valid    <= slot_p2.valid;   // Stage p3.
            phase_out.slot_num <= slot_p2.slot_num;
            phase_out.phase    <= rhythm_phase_p2;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/slot_sequencer.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

module slot_sequencer (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            rhythm_en,
    output opl_pkg::slot_t slot_p0
);
    import opl_pkg::*;

    localparam int CNT_W = $clog2(`OPL_SAMPLE_PERIOD);

    logic [CNT_W-1:0] cycle_cnt;     // Position in the sample period.
    logic             period_end;
    seq_state_t       state;
    op_type_t         op_type_next;  // Type of the slot about to issue.

    assign period_end = cycle_cnt == CNT_W'(`OPL_SAMPLE_PERIOD - 1);

    // Rhythm slots only get their special type in rhythm mode.
    always_comb begin
        op_type_next = OP_NORMAL;
        if (rhythm_en) begin
            case (cycle_cnt)
                `OPL_SLOT_HH:  op_type_next = OP_HI_HAT;
                `OPL_SLOT_TOM: op_type_next = OP_TOM_TOM;
                `OPL_SLOT_SD:  op_type_next = OP_SNARE_DRUM;
                `OPL_SLOT_TC:  op_type_next = OP_TOP_CYMBAL;
                default:       op_type_next = OP_NORMAL;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= '0;
            state     <= SEQ_ISSUE;
            slot_p0   <= '0;
        end else begin
            cycle_cnt <= period_end ? '0 : cycle_cnt + 1'b1;
            slot_p0   <= '0;                              // Bubble by default.
            case (state)
                SEQ_ISSUE: begin
                    slot_p0.valid        <= 1'b1;
                    slot_p0.sample_start <= cycle_cnt == '0;
                    slot_p0.slot_num     <= slot_num_t'(cycle_cnt);
                    slot_p0.op_type      <= op_type_next;
                    if (cycle_cnt == CNT_W'(`OPL_NUM_SLOTS - 1)) begin
                        state <= SEQ_IDLE;                // Last slot out.
                    end
                end
                SEQ_IDLE: begin
                    if (period_end) begin
                        state <= SEQ_ISSUE;               // Next sample.
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== include/opl_defs_defs.svh ====
`ifndef OPL_DEFS_DEFS_SVH
`define OPL_DEFS_DEFS_SVH

//////////////////////////////////////////////////
// Slot timing
//////////////////////////////////////////////////
`define OPL_NUM_SLOTS 18          // Operator slots per sample.
`define OPL_SLOT_WIDTH 5          // Bits in a slot number.
`define OPL_SAMPLE_PERIOD 32      // Clocks per sample, slots plus 3 at least.

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define OPL_PHASE_ACC_WIDTH 20    // Accumulator, wraps mod 2**20.
`define OPL_PHASE_WIDTH 10        // Top bits of the accumulator.
`define OPL_INC_WIDTH 16          // Per-slot phase increment.
`define OPL_NOISE_WIDTH 23        // Rhythm noise LFSR.

// Rhythm voices in bank 0.
`define OPL_SLOT_HH 13            // Hi-hat.
`define OPL_SLOT_TOM 14           // Tom-tom.
`define OPL_SLOT_SD 16            // Snare drum.
`define OPL_SLOT_TC 17            // Top cymbal.

//////////////////////////////////////////////////
// Register port
//////////////////////////////////////////////////
`define OPL_AXIL_ADDR_WIDTH 8     // Byte address.
`define OPL_AXIL_DATA_WIDTH 32    // One word per register.
`define OPL_AXIL_RESP_OKAY 2'b00  // Only response ever given.
`define OPL_REG_INC_BASE 'h00     // Increment of slot n at base plus 4n.
`define OPL_REG_RHYTHM 'h80       // Bit 0 is the rhythm enable.

`endif

// ==== list.f ====
+incdir+include
hdl/opl_pkg.sv
hdl/phase_regs_axil.sv
hdl/slot_sequencer.sv
hdl/phase_accumulator.sv
hdl/rhythm_phase.sv
hdl/opl_rhythm_top.sv
tests/opl_rhythm_properties.sv
tests/opl_rhythm_tb.sv

// ==== tests/opl_rhythm_properties.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

module opl_rhythm_properties (
    input wire                              clk,
    input wire                              arst_n,
    input var  opl_pkg::slot_t              slot_p0,
    input var  opl_pkg::slot_t              slot_p2,
    input var  opl_pkg::phase_out_t         phase_out,
    input wire                              bvalid,
    input wire                              bready,
    input wire                              rvalid,
    input wire                              rready,
    input wire [`OPL_AXIL_DATA_WIDTH-1:0]   rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import opl_pkg::*;

    int prop_errors = 0;    // Failed assertions so far.

    //////////////////////////////////////////////////
    // Output stream
    //////////////////////////////////////////////////
    // Issue in p0, output register in p3.
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        phase_out.valid == $past(slot_p0.valid, 3))
    else begin
        prop_errors++;
        $error("Output valid does not follow slot issue by 3 cycles.");
    end

    a_order_first: assert property (@(posedge clk) disable iff (!arst_n)
        phase_out.valid && !$past(phase_out.valid) |-> phase_out.slot_num == '0)
    else begin
        prop_errors++;
        $error("Sample period does not start with slot 0.");
    end

    a_order_next: assert property (@(posedge clk) disable iff (!arst_n)
        phase_out.valid && $past(phase_out.valid) |->
            phase_out.slot_num == $past(phase_out.slot_num) + 1'b1)
    else begin
        prop_errors++;
        $error("Output slot numbers are not consecutive.");
    end

    a_order_range: assert property (@(posedge clk) disable iff (!arst_n)
        phase_out.valid |-> phase_out.slot_num < `OPL_NUM_SLOTS)
    else begin
        prop_errors++;
        $error("Output slot number out of range.");
    end

    // Cymbal low bits are fixed, only bit 9 moves.
    a_cymbal: assert property (@(posedge clk) disable iff (!arst_n)
        $past(slot_p2.valid && slot_p2.op_type == OP_TOP_CYMBAL) |->
            phase_out.phase[8:0] == 9'h080)
    else begin
        prop_errors++;
        $error("Top cymbal phase has wrong low bits.");
    end

    //////////////////////////////////////////////////
    // Register port responses
    //////////////////////////////////////////////////
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid)
    else begin
        prop_errors++;
        $error("Write response dropped before bready.");
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        prop_errors++;
        $error("Read response dropped or changed before rready.");
    end

endmodule

`default_nettype wire

// ==== tests/opl_rhythm_tb.sv ====
`default_nettype none

`include "opl_defs_defs.svh"

module opl_rhythm_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import opl_pkg::*;

    localparam int ADDR_W     = `OPL_AXIL_ADDR_WIDTH;
    localparam int DATA_W     = `OPL_AXIL_DATA_WIDTH;
    localparam int WAIT_LIMIT = 200;                      // Several sample periods.
    localparam slot_num_t HH  = slot_num_t'(`OPL_SLOT_HH);
    localparam slot_num_t SD  = slot_num_t'(`OPL_SLOT_SD);
    localparam slot_num_t TC  = slot_num_t'(`OPL_SLOT_TC);

    logic                clk = 1'b0;
    logic                arst_n;
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    logic [DATA_W-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;
    phase_out_t          phase_out;

    integer     seed = 77389;
    int         errors = 0;
    int         timeouts = 0;
    int         outputs = 0;                              // Valid output words seen.
    int         rhythm_checks = 0;
    phase_acc_t model_acc [`OPL_NUM_SLOTS];               // Reference accumulators.
    phase_inc_t model_inc [`OPL_NUM_SLOTS];
    logic       model_rhythm = 1'b0;

    opl_rhythm_top i_dut (
        .clk, .arst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .phase_out
    );

    bind opl_rhythm_top opl_rhythm_properties i_props (
        .clk(clk), .arst_n(arst_n),
        .slot_p0(slot_p0), .slot_p2(slot_p2), .phase_out(phase_out),
        .bvalid(bvalid), .bready(bready),
        .rvalid(rvalid), .rready(rready), .rdata(rdata)
    );

    always #5 clk = ~clk;                                 // 10 ns period.

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic phase_t top_bits(input phase_acc_t acc);
        return acc[`OPL_PHASE_ACC_WIDTH-1 -: `OPL_PHASE_WIDTH];
    endfunction

    // OPL ring modulation of hi-hat and top cymbal.
    function automatic logic ring_mod(input phase_t hh, input phase_t tc);
        return (hh[2] ^ hh[7]) | (hh[3] ^ hh[5]) | (tc[3] ^ tc[5]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp) else begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_slot(input slot_num_t s, input phase_t act);
        phase_t hh;
        phase_t tc;
        logic   rm;
        model_acc[s] = model_acc[s] + phase_acc_t'(model_inc[s]);  // Wraps mod 2**20.
        hh = top_bits(model_acc[HH]);                   // Friend phases.
        tc = top_bits(model_acc[TC]);
        rm = ring_mod(hh, tc);
        if (!model_rhythm || !(s == HH || s == SD || s == TC)) begin
            check_value(model_rhythm ? "rhythm_normal" : "pass_through",
                        top_bits(model_acc[s]), act);
        end else if (s == HH) begin
            rhythm_checks++;
            assert (act[8:0] == 9'h034 || act[8:0] == 9'h0d0) else begin
                errors++;
                $display("Error: hi_hat_low expected 0x34 or 0xd0 actual 0x%0h", act[8:0]);
            end
            check_value("hi_hat_bit9", rm, act[9]);
        end else if (s == SD) begin
            rhythm_checks++;
            check_value("snare_bit9", hh[8], act[9]);
            check_value("snare_low", 0, act[7:0]);
        end else begin
            rhythm_checks++;
            check_value("top_cymbal", {rm, 9'h080}, act);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n && phase_out.valid) begin
            outputs++;
            check_slot(phase_out.slot_num, phase_out.phase);
        end
    end

    //////////////////////////////////////////////////
    // Waits and bus tasks
    //////////////////////////////////////////////////
    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    // Returns just after the last slot of a period leaves the pipeline.
    task automatic wait_window();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(phase_out.valid && phase_out.slot_num == TC) && n < WAIT_LIMIT);
        if (!(phase_out.valid && phase_out.slot_num == TC)) begin
            note_timeout("the end of a sample period");
        end
    endtask

    task automatic wait_samples(input int count);
        repeat (count) wait_window();
    endtask

    // Writes land in the idle gap so no slot sees half an update.
    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int n;
        wait_window();
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= '1;
        wvalid  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(awready && wready) && n < WAIT_LIMIT);
        if (!(awready && wready)) begin
            note_timeout("awready and wready");
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!bvalid && n < WAIT_LIMIT);
        if (!bvalid) begin
            note_timeout("bvalid");
        end
        check_value("write_resp", `OPL_AXIL_RESP_OKAY, bresp);
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int n;
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < WAIT_LIMIT);
        if (!arready) begin
            note_timeout("arready");
        end
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rvalid && n < WAIT_LIMIT);
        if (!rvalid) begin
            note_timeout("rvalid");
        end
        check_value("read_resp", `OPL_AXIL_RESP_OKAY, rresp);
        data = rdata;
    endtask

    task automatic write_inc(input int slot, input phase_inc_t value);
        axil_write(ADDR_W'(`OPL_REG_INC_BASE + 4 * slot), DATA_W'(value));
        model_inc[slot] = value;
    endtask

    task automatic write_rhythm(input logic en);
        axil_write(ADDR_W'(`OPL_REG_RHYTHM), DATA_W'(en));
        model_rhythm = en;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        phase_inc_t        value;
        logic [DATA_W-1:0] rd;
        int                seen;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
            model_acc[i] = '0;
            model_inc[i] = '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Register access, stream checked in pass-through all along.
        for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
            value = phase_inc_t'($random(seed));
            write_inc(i, value);
        end
        for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
            axil_read(ADDR_W'(`OPL_REG_INC_BASE + 4 * i), rd);
            check_value("inc_readback", model_inc[i], rd);
        end
        axil_read(ADDR_W'('h48), rd);                   // Just past slot 17.
        check_value("unmapped_read", 0, rd);
        axil_read(ADDR_W'('hfc), rd);
        check_value("unmapped_read", 0, rd);
        axil_read(ADDR_W'(`OPL_REG_RHYTHM), rd);
        check_value("rhythm_readback", 0, rd);
        wait_samples(8);

        // Rhythm mode.
        write_rhythm(1'b1);
        axil_read(ADDR_W'(`OPL_REG_RHYTHM), rd);
        check_value("rhythm_readback", 1, rd);
        wait_samples(40);

        // Responses held back while the stream runs on.
        bready <= 1'b0;
        value = phase_inc_t'($random(seed));
        write_inc(3, value);
        seen = outputs;
        repeat (20) @(posedge clk);
        assert (bvalid) else begin
            errors++;
            $display("Write response was lost while bready was low");
        end
        bready <= 1'b1;
        rready <= 1'b0;
        @(posedge clk);
        axil_read(ADDR_W'(`OPL_REG_INC_BASE + 4 * 3), rd);
        repeat (20) @(posedge clk);
        assert (rvalid) else begin
            errors++;
            $display("Read response was lost while rready was low");
        end
        check_value("held_read", model_inc[3], rdata);
        rready <= 1'b1;
        @(posedge clk);
        assert (outputs > seen) else begin
            errors++;
            $display("Output stream stalled during response back-pressure");
        end
        wait_samples(4);
        write_rhythm(1'b0);
        wait_samples(4);
        assert (rhythm_checks > 0) else begin
            errors++;
            $display("Rhythm slots were never checked");
        end

        $display("Closing: %0d check errors, %0d assertion failures, %0d timeouts",
                 errors, i_dut.i_props.prop_errors, timeouts);
        if (errors == 0 && timeouts == 0 && i_dut.i_props.prop_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
